/* project.f */
keymap_pkg.sv
audio_pkg.sv
key_event_decoder.sv
note_select.sv
buzzer_ctl.sv
audio_serializer.sv
keyboard_piano.sv
keyboard_piano_chk.sv
keyboard_piano_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the keyboard piano testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --top-module keyboard_piano_tb \
    -f project.f \
    -o keyboard_piano_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/keyboard_piano_sim)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "ALL CHECKS PASSED"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1

/* keyboard_piano_tb.sv */
module keyboard_piano_tb;

    import keymap_pkg::*;
    import audio_pkg::*;

    //////////////////////////////////////////////////
    // Constants and signals
    //////////////////////////////////////////////////

    localparam int sck_div = 4;

    // Two 16-bit words, each bit two sck halves of sck_div clocks
    localparam int frame_cycles = 2 * 16 * 2 * sck_div;

    // Summed test length plus margin
    localparam int timeout_cycles = 600000;

    // Divisor plus one for Q and J
    localparam int half_q = 191572;
    localparam int half_j = 50608;

    // Square-wave sample levels
    localparam logic [sample_w-1:0] level_low  = 16'hB000;
    localparam logic [sample_w-1:0] level_high = 16'h5FFF;

    logic                 clk;
    logic                 rst_n;
    logic [7:0]           scan_byte;
    logic                 scan_valid;
    logic                 sck;
    logic                 lrck;
    logic                 sdin;
    logic                 key_valid;
    logic [key_count-1:0] key_down;

    // Run bookkeeping
    int cycle_cnt     = 0;
    int error_cnt     = 0;
    int test_cnt      = 0;
    int test_fail_cnt = 0;

    keyboard_piano #(
        .sck_div (sck_div)
    ) u_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .scan_byte  (scan_byte),
        .scan_valid (scan_valid),
        .sck        (sck),
        .lrck       (lrck),
        .sdin       (sdin),
        .key_valid  (key_valid),
        .key_down   (key_down)
    );

    //////////////////////////////////////////////////
    // Clock, cycle count, watchdog
    //////////////////////////////////////////////////

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk)
    begin
        cycle_cnt <= cycle_cnt + 1;
    end

    initial
    begin
        repeat (timeout_cycles) @(posedge clk);
        $display("Simulation timed out after %0d cycles", timeout_cycles);
        $display("CHECKS FAILED");
        $finish;
    end

    //////////////////////////////////////////////////
    // Reporting helpers
    //////////////////////////////////////////////////

    task automatic report_fail(input string msg);
        error_cnt++;
        $display("[FAIL] %0t: %s", $time, msg);
    endtask

    // One line per finished test
    task automatic close_test(input string name, input int errors_before);
        test_cnt++;
        if (error_cnt != errors_before)
        begin
            test_fail_cnt++;
            $display("%-22s fail (%0d errors)", name, error_cnt - errors_before);
        end
        else
        begin
            $display("%-22s pass", name);
        end
    endtask

    //////////////////////////////////////////////////
    // Scan-code drivers
    //////////////////////////////////////////////////

    // One-cycle strobe, returns on the edge that samples it
    task automatic send_byte(input logic [7:0] b);
        @(posedge clk);
        scan_byte  <= b;
        scan_valid <= 1'b1;
        @(posedge clk);
        scan_valid <= 1'b0;
    endtask

    task automatic press_key(input logic [key_code_w-1:0] code);
        if (code[8])
            send_byte(scan_ext_prefix);
        send_byte(code[7:0]);
    endtask

    task automatic release_key(input logic [key_code_w-1:0] code);
        if (code[8])
            send_byte(scan_ext_prefix);
        send_byte(scan_break_prefix);
        send_byte(code[7:0]);
    endtask

    // Pulse in the cycle after the final strobe, then gone
    task automatic expect_pulse(input string what);
        @(negedge clk);
        if (key_valid !== 1'b1)
            report_fail($sformatf("%s: key_valid low after final byte", what));
        @(negedge clk);
        if (key_valid !== 1'b0)
            report_fail($sformatf("%s: key_valid high for more than one cycle", what));
    endtask

    task automatic expect_quiet(input int cycles, input string what);
        repeat (cycles)
        begin
            @(negedge clk);
            if (key_valid !== 1'b0)
                report_fail($sformatf("%s: unexpected key_valid pulse", what));
        end
    endtask

    //////////////////////////////////////////////////
    // Serial frame capture
    //////////////////////////////////////////////////

    // Outputs sampled on the falling clk edge, away from updates
    task automatic capture_frame(output logic [sample_w-1:0] left_w,
                                 output logic [sample_w-1:0] right_w,
                                 output int frame_cycle);
        logic        prev_lrck;
        logic        prev_sck;
        logic        found;
        logic [31:0] bits;
        int          bit_idx;
        found = 1'b0;
        bits  = '0;
        @(negedge clk);
        prev_lrck = lrck;
        // Frame opens on the lrck fall
        while (!found)
        begin
            @(negedge clk);
            found     = prev_lrck && !lrck;
            prev_lrck = lrck;
        end
        frame_cycle = cycle_cnt;
        prev_sck    = sck;
        bit_idx     = 0;
        while (bit_idx < 32)
        begin
            @(negedge clk);
            if (!prev_sck && sck)
            begin
                bits = {bits[30:0], sdin};
                // Left word with lrck low, right word with lrck high
                if (lrck != (bit_idx >= 16))
                    report_fail($sformatf("lrck wrong at bit %0d of frame", bit_idx));
                bit_idx++;
            end
            prev_sck = sck;
        end
        left_w  = bits[31:16];
        right_w = bits[15:0];
        if (left_w != right_w)
            report_fail($sformatf("left %h differs from right %h", left_w, right_w));
        if (left_w != level_low && left_w != level_high)
            report_fail($sformatf("sample %h is not a square-wave level", left_w));
    endtask

    // Cycles between two successive left-word changes, -1 if none
    task automatic measure_half_period(input int max_frames, output int half_cycles);
        logic [sample_w-1:0] cur;
        logic [sample_w-1:0] left_w;
        logic [sample_w-1:0] right_w;
        int                  fc;
        int                  first_cycle;
        int                  changes;
        int                  n;
        half_cycles = -1;
        first_cycle = 0;
        changes     = 0;
        n           = 0;
        capture_frame(cur, right_w, fc);
        while (changes < 2 && n < max_frames)
        begin
            capture_frame(left_w, right_w, fc);
            n++;
            if (left_w != cur)
            begin
                cur = left_w;
                changes++;
                if (changes == 1)
                    first_cycle = fc;
                else
                    half_cycles = fc - first_cycle;
            end
        end
    endtask

    //////////////////////////////////////////////////
    // Directed tests
    //////////////////////////////////////////////////

    task automatic check_reset_state();
        int                  e0;
        int                  fc;
        logic [sample_w-1:0] l;
        logic [sample_w-1:0] r;
        e0 = error_cnt;
        @(negedge clk);
        if (key_valid !== 1'b0)
            report_fail("key_valid high after reset");
        if (key_down !== '0)
            report_fail("key_down not zero after reset");
        // Idle tone, every word one of the two levels
        repeat (3) capture_frame(l, r, fc);
        close_test("reset state", e0);
    endtask

    task automatic track_make_break();
        int e0;
        e0 = error_cnt;
        press_key(9'h01C);
        expect_pulse("make A");
        if (key_down[9'h01C] !== 1'b1)
            report_fail("key_down bit 1C not set by make");
        press_key(9'h175);
        expect_pulse("make E0 75");
        if (key_down[9'h175] !== 1'b1)
            report_fail("key_down bit 175 not set by extended make");
        release_key(9'h01C);
        expect_pulse("break A");
        if (key_down[9'h01C] !== 1'b0)
            report_fail("key_down bit 1C not cleared by break");
        if (key_down[9'h175] !== 1'b1)
            report_fail("key_down bit 175 lost on break of 1C");
        release_key(9'h175);
        expect_pulse("break E0 75");
        if (key_down !== '0)
            report_fail("key_down not zero after all breaks");
        close_test("make and break", e0);
    endtask

    task automatic ignore_lone_prefixes();
        int e0;
        e0 = error_cnt;
        send_byte(scan_ext_prefix);
        expect_quiet(4, "lone E0");
        send_byte(scan_break_prefix);
        expect_quiet(4, "lone F0");
        // Closing byte ends the pending sequence as a break of 11C
        send_byte(8'h1C);
        expect_pulse("closing byte");
        if (key_down !== '0)
            report_fail("key_down changed by break of unheld key");
        close_test("prefix bytes", e0);
    endtask

    task automatic measure_pitch();
        int e0;
        int half;
        e0 = error_cnt;
        press_key(9'h015);
        repeat (8) @(posedge clk);
        measure_half_period(1600, half);
        if (half < 0)
        begin
            error_cnt++;
            $display("No tone transitions seen while Q was held");
        end
        else if (half < half_q - frame_cycles || half > half_q + frame_cycles)
            report_fail($sformatf("Q half period %0d, expected %0d", half, half_q));
        // J pressed with Q still held, last change wins
        press_key(9'h03B);
        repeat (8) @(posedge clk);
        measure_half_period(500, half);
        if (half < 0)
        begin
            error_cnt++;
            $display("No tone transitions seen while J was held");
        end
        else if (half < half_j - frame_cycles || half > half_j + frame_cycles)
            report_fail($sformatf("J half period %0d, expected %0d", half, half_j));
        close_test("pitch", e0);
    endtask

    task automatic release_note();
        int e0;
        int half;
        e0 = error_cnt;
        release_key(9'h03B);
        release_key(9'h015);
        repeat (8) @(posedge clk);
        if (key_down !== '0)
            report_fail("key_down not zero after releasing Q and J");
        // Idle tone aliases against the frame rate, one or two frames
        measure_half_period(16, half);
        if (half < 0 || half > 2 * frame_cycles)
            report_fail($sformatf("idle half period %0d after release", half));
        close_test("release", e0);
    endtask

    task automatic verify_frame_format();
        int                  e0;
        int                  fc;
        logic [sample_w-1:0] l;
        logic [sample_w-1:0] r;
        e0 = error_cnt;
        press_key(9'h01C);
        repeat (16) capture_frame(l, r, fc);
        release_key(9'h01C);
        repeat (4) capture_frame(l, r, fc);
        close_test("serializer format", e0);
    endtask

    //////////////////////////////////////////////////
    // Sequence
    //////////////////////////////////////////////////

    initial
    begin
        rst_n      = 1'b1;
        scan_byte  = 8'h00;
        scan_valid = 1'b0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b0;
        check_reset_state();
        track_make_break();
        ignore_lone_prefixes();
        measure_pitch();
        release_note();
        verify_frame_format();
        $display("Summary: %0d tests, %0d failed, %0d errors", test_cnt, test_fail_cnt,
                 error_cnt);
        if (error_cnt == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

endmodule

/* keyboard_piano_chk.sv */
module keyboard_piano_chk (
    input logic       clk,
    input logic       rst_n,
    input logic [7:0] scan_byte,
    input logic       scan_valid,
    input logic       key_valid,
    input logic       sck,
    input logic       lrck
);

    import keymap_pkg::*;

    // Strobed byte that completes a key event
    logic key_byte;

    assign key_byte = scan_valid && (scan_byte != scan_ext_prefix)
                      && (scan_byte != scan_break_prefix);

    //////////////////////////////////////////////////
    // Decoder properties
    //////////////////////////////////////////////////

    key_valid_single: assert property (
        @(posedge clk) disable iff (rst_n) key_valid |=> !key_valid
    ) else $error("key_valid held for more than one cycle");

    key_byte_pulses: assert property (
        @(posedge clk) disable iff (rst_n) key_byte |=> key_valid
    ) else $error("key byte not followed by key_valid");

    //////////////////////////////////////////////////
    // Serializer framing
    //////////////////////////////////////////////////

    // Word clock moves together with a bit clock fall
    lrck_on_sck_fall: assert property (
        @(posedge clk) disable iff (rst_n)
        (lrck != $past(lrck)) |-> ($past(sck) && !sck)
    ) else $error("lrck changed away from an sck fall");

endmodule

bind key_event_decoder keyboard_piano_chk u_decoder_chk (
    .clk        (clk),
    .rst_n      (rst_n),
    .scan_byte  (scan_byte),
    .scan_valid (scan_valid),
    .key_valid  (key_valid),
    .sck        (1'b0),
    .lrck       (1'b0)
);

bind audio_serializer keyboard_piano_chk u_serializer_chk (
    .clk        (clk),
    .rst_n      (rst_n),
    .scan_byte  (8'h00),
    .scan_valid (1'b0),
    .key_valid  (1'b0),
    .sck        (sck),
    .lrck       (lrck)
);

/* keyboard_piano.sv */
module keyboard_piano #(
    parameter int sck_div = 4
) (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic [7:0]                          scan_byte,
    input  logic                                scan_valid,
    output logic                                sck,
    output logic                                lrck,
    output logic                                sdin,
    output logic                                key_valid,
    output logic [keymap_pkg::key_count-1:0]    key_down
);

    import keymap_pkg::*;
    import audio_pkg::*;

    // Most recent key event
    logic [key_code_w-1:0] last_change;

    // Selected note index
    logic [note_idx_w-1:0] sound;

    // Square-wave samples
    logic [sample_w-1:0]   audio_left;
    logic [sample_w-1:0]   audio_right;

    //////////////////////////////////////////////////
    // Keyboard side
    //////////////////////////////////////////////////

    key_event_decoder u_decoder (
        .clk         (clk),
        .rst_n       (rst_n),
        .scan_byte   (scan_byte),
        .scan_valid  (scan_valid),
        .key_down    (key_down),
        .last_change (last_change),
        .key_valid   (key_valid)
    );

    note_select u_note (
        .clk         (clk),
        .rst_n       (rst_n),
        .last_change (last_change),
        .key_valid   (key_valid),
        .sound       (sound)
    );

    //////////////////////////////////////////////////
    // Audio side
    //////////////////////////////////////////////////

    buzzer_ctl u_buzzer (
        .clk         (clk),
        .rst_n       (rst_n),
        .sound       (sound),
        .key_down    (key_down),
        .last_change (last_change),
        .audio_left  (audio_left),
        .audio_right (audio_right)
    );

    // Codec bit clock rate set here
    audio_serializer #(
        .sck_div (sck_div)
    ) u_serializer (
        .clk         (clk),
        .rst_n       (rst_n),
        .audio_left  (audio_left),
        .audio_right (audio_right),
        .sck         (sck),
        .lrck        (lrck),
        .sdin        (sdin)
    );

endmodule

/* audio_serializer.sv */
module audio_serializer #(
    parameter int sck_div = 4
) (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic [audio_pkg::sample_w-1:0]  audio_left,
    input  logic [audio_pkg::sample_w-1:0]  audio_right,
    output logic                            sck,
    output logic                            lrck,
    output logic                            sdin
);

    import audio_pkg::*;

    // Prescaler width, at least one bit
    localparam int pre_w = (sck_div > 1) ? $clog2(sck_div) : 1;

    // Two words per frame
    localparam int bit_cnt_w = $clog2(2 * sample_w);

    logic [pre_w-1:0]     pre_cnt;
    logic                 sck_tick;
    logic                 sck_fall;

    // Bit position within the frame
    logic [bit_cnt_w-1:0] bit_cnt;
    logic [bit_cnt_w-1:0] bit_cnt_next;
    logic                 word_start;

    // Word data
    logic [sample_w-1:0]  right_hold;
    logic [sample_w-1:0]  load_word;
    logic [sample_w-1:0]  shift_reg;

    //////////////////////////////////////////////////
    // Bit clock
    //////////////////////////////////////////////////

    assign sck_tick = (pre_cnt == pre_w'(sck_div - 1));
    assign sck_fall = sck_tick && sck;

    always_ff @(posedge clk or posedge rst_n)
    begin
        if (rst_n)
        begin
            pre_cnt <= '0;
            sck     <= 1'b0;
        end
        else if (sck_tick)
        begin
            pre_cnt <= '0;
            sck     <= ~sck;
        end
        else
        begin
            pre_cnt <= pre_cnt + 1'b1;
        end
    end

    //////////////////////////////////////////////////
    // Frame counter and word clock
    //////////////////////////////////////////////////

    assign bit_cnt_next = bit_cnt + 1'b1;

    // Low bits wrap at each left or right word
    assign word_start = (bit_cnt_next[bit_cnt_w-2:0] == '0);

    // Left comes straight from the input at the lrck fall
    assign load_word = bit_cnt_next[bit_cnt_w-1] ? right_hold : audio_left;

    // Starts at the last bit so the first fall opens a left word
    always_ff @(posedge clk or posedge rst_n)
    begin
        if (rst_n)
        begin
            bit_cnt <= '1;
            lrck    <= 1'b0;
            sdin    <= 1'b0;
        end
        else if (sck_fall)
        begin
            bit_cnt <= bit_cnt_next;
            lrck    <= bit_cnt_next[bit_cnt_w-1];
            // MSB of a new word set up for the next rise
            if (word_start)
                sdin <= load_word[sample_w-1];
            else
                sdin <= shift_reg[sample_w-1];
        end
    end

    //////////////////////////////////////////////////
    // Shift register
    //////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (sck_fall)
        begin
            if (word_start)
                shift_reg <= {load_word[sample_w-2:0], 1'b0};
            else
                shift_reg <= {shift_reg[sample_w-2:0], 1'b0};
            // Right sample frozen alongside the left one
            if (bit_cnt_next == '0)
                right_hold <= audio_right;
        end
    end

endmodule

/* buzzer_ctl.sv */
module buzzer_ctl (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic [keymap_pkg::note_idx_w-1:0]   sound,
    input  logic [keymap_pkg::key_count-1:0]    key_down,
    input  logic [keymap_pkg::key_code_w-1:0]   last_change,
    output logic [audio_pkg::sample_w-1:0]      audio_left,
    output logic [audio_pkg::sample_w-1:0]      audio_right
);

    import keymap_pkg::*;
    import audio_pkg::*;

    // Divisor for the current note
    logic [div_w-1:0] note_div;

    // Tone counter and square-wave level
    logic [div_w-1:0] clk_cnt;
    logic             wave;

    // Last changed key still pressed
    logic note_held;

    // Index within the note table
    logic note_in_range;

    //////////////////////////////////////////////////
    // Divisor select
    //////////////////////////////////////////////////

    assign note_held     = key_down[last_change];
    assign note_in_range = (sound <= note_idx_w'(note_count));

    always_comb
    begin
        if (note_held && note_in_range)
            note_div = note_divisors[sound];
        else
            note_div = idle_div;
    end

    //////////////////////////////////////////////////
    // Tone counter
    //////////////////////////////////////////////////

    // Compare with >= so a drop to a shorter divisor
    // turns over at once instead of wrapping the counter
    always_ff @(posedge clk or posedge rst_n)
    begin
        if (rst_n)
        begin
            clk_cnt <= '0;
            wave    <= 1'b0;
        end
        else if (clk_cnt >= note_div)
        begin
            clk_cnt <= '0;
            wave    <= ~wave;
        end
        else
        begin
            clk_cnt <= clk_cnt + 1'b1;
        end
    end

    // Same level on both channels
    assign audio_left  = wave ? amp_high : amp_low;
    assign audio_right = wave ? amp_high : amp_low;

endmodule

/* note_select.sv */
module note_select (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic [keymap_pkg::key_code_w-1:0]   last_change,
    input  logic                                key_valid,
    output logic [keymap_pkg::note_idx_w-1:0]   sound
);

    import keymap_pkg::*;

    // Table position of last_change, 0 when absent
    logic [note_idx_w-1:0] match_idx;

    //////////////////////////////////////////////////
    // Note table lookup
    //////////////////////////////////////////////////

    always_comb
    begin
        match_idx = '0;
        // Codes are unique, at most one entry hits
        for (int i = 1; i <= note_count; i++)
        begin
            if (last_change == note_key_codes[i])
            begin
                match_idx = note_idx_w'(i);
            end
        end
    end

    //////////////////////////////////////////////////
    // Note register
    //////////////////////////////////////////////////

    // Follows every key event, press or release
    // Held state is checked downstream in the buzzer
    always_ff @(posedge clk or posedge rst_n)
    begin
        if (rst_n)
        begin
            sound <= '0;
        end
        else if (key_valid)
        begin
            sound <= match_idx;
        end
    end

endmodule

/* key_event_decoder.sv */
module key_event_decoder (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic [7:0]                          scan_byte,
    input  logic                                scan_valid,
    output logic [keymap_pkg::key_count-1:0]    key_down,
    output logic [keymap_pkg::key_code_w-1:0]   last_change,
    output logic                                key_valid
);

    import keymap_pkg::*;

    // Prefix flags seen since the last completed event
    logic ext_flag;
    logic brk_flag;

    // Byte classification
    logic is_ext;
    logic is_brk;
    logic is_event;

    // Key code of the byte that completes an event
    logic [key_code_w-1:0] event_code;

    //////////////////////////////////////////////////
    // Byte decode
    //////////////////////////////////////////////////

    assign is_ext   = scan_valid && (scan_byte == scan_ext_prefix);
    assign is_brk   = scan_valid && (scan_byte == scan_break_prefix);

    // Anything that is not a prefix ends the sequence
    assign is_event = scan_valid && !is_ext && !is_brk;

    // Extended flag lands in the top bit
    assign event_code = {ext_flag, scan_byte};

    //////////////////////////////////////////////////
    // Prefix flags
    //////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst_n)
    begin
        if (rst_n)
        begin
            ext_flag <= 1'b0;
            brk_flag <= 1'b0;
        end
        else if (is_ext)
        begin
            ext_flag <= 1'b1;
        end
        else if (is_brk)
        begin
            brk_flag <= 1'b1;
        end
        else if (is_event)
        begin
            // Flags only apply to one key
            ext_flag <= 1'b0;
            brk_flag <= 1'b0;
        end
    end

    //////////////////////////////////////////////////
    // Held-key bitmap and event output
    //////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst_n)
    begin
        if (rst_n)
        begin
            key_down    <= '0;
            last_change <= '0;
            key_valid   <= 1'b0;
        end
        else
        begin
            // Single-cycle pulse per completed event
            key_valid <= is_event;
            if (is_event)
            begin
                // Make sets, break clears
                key_down[event_code] <= ~brk_flag;
                last_change          <= event_code;
            end
        end
    end

endmodule

/* audio_pkg.sv */
package audio_pkg;

    //////////////////////////////////////////////////
    // Sample format
    //////////////////////////////////////////////////

    // Codec word width, same for left and right
    localparam int sample_w = 16;

    //////////////////////////////////////////////////
    // Tone divider
    //////////////////////////////////////////////////

    // Counter and divisor width
    localparam int div_w = 22;

    // Divisor used when no note sounds
    localparam logic [div_w-1:0] idle_div = 22'd2;

    // Idle entry plus fourteen notes
    localparam int note_div_count = 15;

    // Half period is divisor plus one clocks
    localparam logic [div_w-1:0] note_divisors [0:note_div_count-1] = '{
        idle_div,
        22'd191571, 22'd170241, 22'd151699, 22'd143266,
        22'd127511, 22'd113636, 22'd101214, 22'd95419,
        22'd85034,  22'd75758,  22'd71633,  22'd63776,
        22'd56818,  22'd50607
    };

    //////////////////////////////////////////////////
    // Square-wave levels
    //////////////////////////////////////////////////

    // Wave low
    localparam logic [sample_w-1:0] amp_low = 16'hB000;

    // Wave high
    localparam logic [sample_w-1:0] amp_high = 16'h5FFF;

endpackage

/* keymap_pkg.sv */
package keymap_pkg;

    //////////////////////////////////////////////////
    // Key code layout
    //////////////////////////////////////////////////

    // Top bit flags an extended (E0) key
    localparam int key_code_w = 9;

    // One bit per possible key code
    localparam int key_count = 512;

    //////////////////////////////////////////////////
    // Scan-code prefixes
    //////////////////////////////////////////////////

    // Extended key prefix
    localparam logic [7:0] scan_ext_prefix = 8'hE0;

    // Break (key released) prefix
    localparam logic [7:0] scan_break_prefix = 8'hF0;

    //////////////////////////////////////////////////
    // Note keys
    //////////////////////////////////////////////////

    localparam int note_count = 14;

    // Index 0 is reserved for no note
    localparam int note_idx_w = 4;

    // Upper row Q..U then home row A..J
    localparam logic [key_code_w-1:0] note_key_codes [1:note_count] = '{
        9'h015, 9'h01D, 9'h024, 9'h02D, 9'h02C, 9'h035, 9'h03C,
        9'h01C, 9'h01B, 9'h023, 9'h02B, 9'h034, 9'h033, 9'h03B
    };

endpackage
